/* design/ndn_fib_pkg.sv */
package ndn_fib_pkg;

    // Name prefix, MSB-aligned
    localparam int PREFIX_W   = 64;
    // Prefix length in bits, 0 to 63
    localparam int LEN_W      = 6;
    // Hash value, selects a table column
    localparam int HASH_W     = 8;
    // One table row per prefix length
    localparam int NUM_LENS   = 64;
    localparam int TABLE_COLS = 1 << HASH_W;
    // Fixed payload size of a forwarded data packet
    localparam int DATA_BYTES = 16;
    localparam int BYTE_CNT_W = 5;

    typedef logic [PREFIX_W-1:0] prefix_t;
    typedef logic [LEN_W-1:0]    plen_t;
    typedef logic [HASH_W-1:0]   hash_t;
    typedef logic [7:0]          byte_t;

    // Route learner
    typedef enum logic [1:0] {
        learn_idle,
        learn_hashing,
        learn_writing
    } learn_state_t;

    // Longest-prefix search, three cycles per probed length
    typedef enum logic [1:0] {
        lookup_idle,
        lookup_hashing,
        lookup_reading,
        lookup_checking
    } lookup_state_t;

    typedef enum logic [1:0] {
        fwd_idle,
        fwd_query,
        fwd_transfer
    } fwd_state_t;

endpackage

/* design/prefix_hash.sv */
`timescale 1ns/1ps

module prefix_hash
    import ndn_fib_pkg::*;
(
    input  logic    clk,
    input  prefix_t prefix,
    input  plen_t   len,
    output hash_t   hash
);

    prefix_t masked;
    hash_t   folded;

    always_comb begin
        // Keep only the top len bits, len of zero keeps nothing
        masked = prefix & ~({PREFIX_W{1'b1}} >> len);
        // Fold the eight bytes together
        folded = '0;
        for (int i = 0; i < PREFIX_W / 8; i++) begin
            folded = folded ^ masked[i*8 +: 8];
        end
        // Mix in the length so equal bits at different lengths differ
        folded = folded ^ hash_t'(len);
    end

    // Result is valid one cycle after the inputs
    always_ff @(posedge clk) begin
        hash <= folded;
    end

endmodule

/* design/fib_valid_table.sv */
`timescale 1ns/1ps

module fib_valid_table
    import ndn_fib_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  wr_en,
    input  plen_t wr_len,
    input  hash_t wr_hash,
    input  plen_t rd_len,
    input  hash_t rd_hash,
    output logic  rd_valid
);

    // One row per prefix length, one valid bit per hash value
    logic [TABLE_COLS-1:0] valid_bits [NUM_LENS];

    // Write port only ever sets a bit, no route removal
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_LENS; r++) begin
                valid_bits[r] <= '0;
            end
        end else if (wr_en) begin
            valid_bits[wr_len][wr_hash] <= 1'b1;
        end
    end

    // Registered read
    // a write to the same entry in this cycle is not yet visible
    always_ff @(posedge clk) begin
        rd_valid <= valid_bits[rd_len][rd_hash];
    end

endmodule

/* design/fib_route_learner.sv */
`timescale 1ns/1ps

module fib_route_learner
    import ndn_fib_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    take,
    input  prefix_t prefix,
    input  plen_t   len,
    output logic    wr_en,
    output plen_t   wr_len,
    output hash_t   wr_hash
);

    learn_state_t state;
    prefix_t      prefix_q;
    plen_t        len_q;

    // Hash of the latched prefix, ready one cycle after the latch
    prefix_hash u_hash (
        .clk    (clk),
        .prefix (prefix_q),
        .len    (len_q),
        .hash   (wr_hash)
    );

    // Latch the packet name whenever the forwarder takes a packet
    always_ff @(posedge clk) begin
        if (take) begin
            prefix_q <= prefix;
            len_q    <= len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= learn_idle;
        end else if (take) begin
            // A new take can land on the write cycle of the previous one
            state <= learn_hashing;
        end else begin
            case (state)
                learn_hashing: state <= learn_writing;
                learn_writing: state <= learn_idle;
                default:       state <= learn_idle;
            endcase
        end
    end

    // Single-cycle write with the hash now settled
    assign wr_en  = (state == learn_writing);
    assign wr_len = len_q;

endmodule

/* design/fib_lpm_lookup.sv */
`timescale 1ns/1ps

module fib_lpm_lookup
    import ndn_fib_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    lookup_valid,
    input  prefix_t lookup_prefix,
    input  plen_t   lookup_len,
    input  logic    rd_valid,
    output logic    lookup_busy,
    output plen_t   rd_len,
    output hash_t   rd_hash,
    output logic    result_valid,
    output logic    result_hit,
    output plen_t   result_len
);

    lookup_state_t state;
    prefix_t       prefix_q;
    // Length currently being probed, counts down
    plen_t         cur_len;

    // Own hash unit, separate from the learner
    prefix_hash u_hash (
        .clk    (clk),
        .prefix (prefix_q),
        .len    (cur_len),
        .hash   (rd_hash)
    );

    // Table address follows the probe
    assign rd_len      = cur_len;
    assign lookup_busy = (state != lookup_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= lookup_idle;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            case (state)
                lookup_idle: begin
                    if (lookup_valid) begin
                        state <= lookup_hashing;
                    end
                end
                // Hash register loads at the end of this cycle
                lookup_hashing: state <= lookup_reading;
                // Table read register loads at the end of this cycle
                lookup_reading: state <= lookup_checking;
                lookup_checking: begin
                    if (rd_valid || cur_len == '0) begin
                        // Hit, or nothing left to shorten
                        result_valid <= 1'b1;
                        state        <= lookup_idle;
                    end else begin
                        state <= lookup_hashing;
                    end
                end
                default: state <= lookup_idle;
            endcase
        end
    end

    // Request latch and length countdown
    always_ff @(posedge clk) begin
        if (state == lookup_idle && lookup_valid) begin
            prefix_q <= lookup_prefix;
            cur_len  <= lookup_len;
        end else if (state == lookup_checking && !rd_valid && cur_len != '0) begin
            cur_len <= cur_len - 1'b1;
        end
    end

    // Result payload, a miss leaves cur_len at zero
    always_ff @(posedge clk) begin
        if (state == lookup_checking) begin
            result_hit <= rd_valid;
            result_len <= cur_len;
        end
    end

endmodule

/* design/content_forwarder.sv */
`timescale 1ns/1ps

module content_forwarder
    import ndn_fib_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    data_ready,
    input  prefix_t data_prefix,
    input  plen_t   data_len,
    input  logic    pit_accept,
    input  logic    pit_reject,
    input  logic    in_byte_valid,
    input  byte_t   in_byte,
    output logic    fwd_busy,
    output logic    take,
    output logic    query_valid,
    output prefix_t query_prefix,
    output plen_t   query_len,
    output logic    out_byte_valid,
    output byte_t   out_byte
);

    localparam logic [BYTE_CNT_W-1:0] LAST_BYTE = BYTE_CNT_W'(DATA_BYTES - 1);

    fwd_state_t            state;
    logic [BYTE_CNT_W-1:0] byte_cnt;

    // New packet only while idle, the learner shares this strobe
    assign take        = data_ready && (state == fwd_idle);
    assign fwd_busy    = (state != fwd_idle);
    // Query held until the PIT answers
    assign query_valid = (state == fwd_query);

    always_ff @(posedge clk) begin
        if (take) begin
            query_prefix <= data_prefix;
            query_len    <= data_len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= fwd_idle;
            byte_cnt       <= '0;
            out_byte_valid <= 1'b0;
        end else begin
            out_byte_valid <= 1'b0;
            case (state)
                fwd_idle: begin
                    if (take) begin
                        state <= fwd_query;
                    end
                end
                fwd_query: begin
                    // Reject wins over accept
                    if (pit_reject) begin
                        state <= fwd_idle;
                    end else if (pit_accept) begin
                        byte_cnt <= '0;
                        state    <= fwd_transfer;
                    end
                end
                fwd_transfer: begin
                    // Source may pause, no back-pressure on the output
                    if (in_byte_valid) begin
                        out_byte_valid <= 1'b1;
                        byte_cnt       <= byte_cnt + 1'b1;
                        if (byte_cnt == LAST_BYTE) begin
                            state <= fwd_idle;
                        end
                    end
                end
                default: state <= fwd_idle;
            endcase
        end
    end

    // Byte pipeline, one cycle from input to output
    always_ff @(posedge clk) begin
        if (state == fwd_transfer && in_byte_valid) begin
            out_byte <= in_byte;
        end
    end

endmodule

/* design/ndn_fib.sv */
`timescale 1ns/1ps

module ndn_fib
    import ndn_fib_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    // Data side
    input  logic    data_ready,
    input  prefix_t data_prefix,
    input  plen_t   data_len,
    input  logic    in_byte_valid,
    input  byte_t   in_byte,
    output logic    fwd_busy,
    // PIT query
    output logic    query_valid,
    output prefix_t query_prefix,
    output plen_t   query_len,
    input  logic    pit_accept,
    input  logic    pit_reject,
    // Payload stream
    output logic    out_byte_valid,
    output byte_t   out_byte,
    // Lookup
    input  logic    lookup_valid,
    input  prefix_t lookup_prefix,
    input  plen_t   lookup_len,
    output logic    lookup_busy,
    output logic    result_valid,
    output logic    result_hit,
    output plen_t   result_len
);

    logic  take;
    logic  wr_en;
    plen_t wr_len;
    hash_t wr_hash;
    plen_t rd_len;
    hash_t rd_hash;
    logic  rd_valid;

    // PIT query and payload path, also gates packet intake
    content_forwarder u_forwarder (
        .clk            (clk),
        .rst            (rst),
        .data_ready     (data_ready),
        .data_prefix    (data_prefix),
        .data_len       (data_len),
        .pit_accept     (pit_accept),
        .pit_reject     (pit_reject),
        .in_byte_valid  (in_byte_valid),
        .in_byte        (in_byte),
        .fwd_busy       (fwd_busy),
        .take           (take),
        .query_valid    (query_valid),
        .query_prefix   (query_prefix),
        .query_len      (query_len),
        .out_byte_valid (out_byte_valid),
        .out_byte       (out_byte)
    );

    // Every taken data packet marks its prefix reachable
    fib_route_learner u_learner (
        .clk     (clk),
        .rst     (rst),
        .take    (take),
        .prefix  (data_prefix),
        .len     (data_len),
        .wr_en   (wr_en),
        .wr_len  (wr_len),
        .wr_hash (wr_hash)
    );

    fib_lpm_lookup u_lookup (
        .clk           (clk),
        .rst           (rst),
        .lookup_valid  (lookup_valid),
        .lookup_prefix (lookup_prefix),
        .lookup_len    (lookup_len),
        .rd_valid      (rd_valid),
        .lookup_busy   (lookup_busy),
        .rd_len        (rd_len),
        .rd_hash       (rd_hash),
        .result_valid  (result_valid),
        .result_hit    (result_hit),
        .result_len    (result_len)
    );

    // Learner writes, lookup reads
    fib_valid_table u_table (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_len   (wr_len),
        .wr_hash  (wr_hash),
        .rd_len   (rd_len),
        .rd_hash  (rd_hash),
        .rd_valid (rd_valid)
    );

endmodule

/* testbench/ndn_fib_tb.sv */
`timescale 1ns/1ps

module ndn_fib_tb
    import ndn_fib_pkg::*;
();

    // Longest search is 64 probes of 3 cycles
    localparam int WAIT_LIMIT = 400;

    logic    clk;
    logic    rst;
    logic    data_ready;
    prefix_t data_prefix;
    plen_t   data_len;
    logic    in_byte_valid;
    byte_t   in_byte;
    logic    fwd_busy;
    logic    query_valid;
    prefix_t query_prefix;
    plen_t   query_len;
    logic    pit_accept;
    logic    pit_reject;
    logic    out_byte_valid;
    byte_t   out_byte;
    logic    lookup_valid;
    prefix_t lookup_prefix;
    plen_t   lookup_len;
    logic    lookup_busy;
    logic    result_valid;
    logic    result_hit;
    plen_t   result_len;

    integer  seed;
    // Reference valid bits with one row per length
    bit      model_valid [NUM_LENS][TABLE_COLS];
    // Last lookup answer seen on the result port
    logic    got_hit;
    plen_t   got_len;

    ndn_fib uut (
        .clk            (clk),
        .rst            (rst),
        .data_ready     (data_ready),
        .data_prefix    (data_prefix),
        .data_len       (data_len),
        .in_byte_valid  (in_byte_valid),
        .in_byte        (in_byte),
        .fwd_busy       (fwd_busy),
        .query_valid    (query_valid),
        .query_prefix   (query_prefix),
        .query_len      (query_len),
        .pit_accept     (pit_accept),
        .pit_reject     (pit_reject),
        .out_byte_valid (out_byte_valid),
        .out_byte       (out_byte),
        .lookup_valid   (lookup_valid),
        .lookup_prefix  (lookup_prefix),
        .lookup_len     (lookup_len),
        .lookup_busy    (lookup_busy),
        .result_valid   (result_valid),
        .result_hit     (result_hit),
        .result_len     (result_len)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Keep the top len bits, fold bytes, mix in the length
    function automatic hash_t ref_hash(prefix_t p, int len);
        prefix_t kept;
        hash_t   h;
        kept = '0;
        for (int b = 0; b < PREFIX_W; b++) begin
            if (b >= PREFIX_W - len) begin
                kept[b] = p[b];
            end
        end
        h = hash_t'(len);
        for (int k = 0; k < PREFIX_W / 8; k++) begin
            h = h ^ kept[k*8 +: 8];
        end
        return h;
    endfunction

    // First hit counting down or a miss with length zero
    function automatic logic [LEN_W:0] ref_lookup(prefix_t p, int len);
        for (int l = len; l >= 0; l--) begin
            if (model_valid[l][ref_hash(p, l)]) begin
                return {1'b1, plen_t'(l)};
            end
        end
        return '0;
    endfunction

    task automatic report_mismatch(string msg);
        $display("mismatch at %0d ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_timeout(string what);
        $display("Timed out at %0d ns while waiting for %s", $time, what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // Step to just after the next rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int r = 0; r < NUM_LENS; r++) begin
            for (int c = 0; c < TABLE_COLS; c++) begin
                model_valid[r][c] = 1'b0;
            end
        end
    endtask

    task automatic wait_fwd_idle();
        int cycles;
        cycles = 0;
        while (fwd_busy) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout("the forwarder to go idle");
            end
            tick();
            cycles++;
        end
    endtask

    // Hand one data packet to the forwarder and wait for its PIT query
    task automatic offer_packet(prefix_t p, plen_t len);
        int cycles;
        wait_fwd_idle();
        data_ready  = 1'b1;
        data_prefix = p;
        data_len    = len;
        tick();
        data_ready = 1'b0;
        cycles = 0;
        while (!query_valid) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout("query_valid after data_ready");
            end
            tick();
            cycles++;
        end
        // Packet was taken so its route is now reachable
        model_valid[len][ref_hash(p, len)] = 1'b1;
        assert (query_prefix == p && query_len == len) else
            report_mismatch($sformatf("query %h/%0d, expected %h/%0d",
                query_prefix, query_len, p, len));
    endtask

    task automatic reject_packet();
        pit_reject = 1'b1;
        tick();
        pit_reject = 1'b0;
        assert (!query_valid && !fwd_busy) else
            report_mismatch("forwarder still busy after reject");
    endtask

    task automatic learn_route(prefix_t p, plen_t len);
        offer_packet(p, len);
        reject_packet();
    endtask

    // Issue one lookup and compare with the reference search
    task automatic run_lookup(prefix_t p, plen_t len);
        int             cycles;
        logic [LEN_W:0] exp;
        exp = ref_lookup(p, len);
        cycles = 0;
        while (lookup_busy) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout("lookup_busy to fall");
            end
            tick();
            cycles++;
        end
        lookup_valid  = 1'b1;
        lookup_prefix = p;
        lookup_len    = len;
        tick();
        lookup_valid = 1'b0;
        cycles = 0;
        while (!result_valid) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout("result_valid of a lookup");
            end
            tick();
            cycles++;
        end
        got_hit = result_hit;
        got_len = result_len;
        assert (got_hit == exp[LEN_W] && got_len == exp[LEN_W-1:0]) else
            report_mismatch($sformatf("lookup %h/%0d gave hit %0b len %0d, expected %0b %0d",
                p, len, got_hit, got_len, exp[LEN_W], exp[LEN_W-1:0]));
    endtask

    task automatic test_reset_state();
        apply_reset();
        assert (!query_valid && !out_byte_valid && !result_valid
                && !fwd_busy && !lookup_busy) else
            report_mismatch("outputs not idle after reset");
        run_lookup({$random(seed), $random(seed)}, 6'd63);
        assert (!got_hit && got_len == '0) else
            report_mismatch("lookup on an empty table did not miss");
    endtask

    task automatic test_exact_match();
        learn_route(64'hA5C3_0F1E_7B2D_9C44, 6'd40);
        run_lookup(64'hA5C3_0F1E_7B2D_9C44, 6'd40);
        assert (got_hit && got_len == 6'd40) else
            report_mismatch("exact match at length 40 not found");
    endtask

    task automatic test_longest_prefix();
        learn_route(64'h3C96_E1D2_4B7A_0F58, 6'd12);
        learn_route(64'h3C96_E1D2_4B7A_0F58, 6'd30);
        run_lookup(64'h3C96_E1D2_4B7A_0F58, 6'd50);
        run_lookup(64'h3C96_E1D2_4B7A_0F58, 6'd20);
    endtask

    task automatic test_accepted_transfer();
        byte_t  expected[$];
        integer r;
        int     sent;
        int     got;
        int     cycles;
        sent = 0;
        got = 0;
        cycles = 0;
        offer_packet(64'h0123_4567_89AB_CDEF, 6'd24);
        pit_accept = 1'b1;
        tick();
        pit_accept = 1'b0;
        assert (!query_valid && fwd_busy) else
            report_mismatch("forwarder did not enter transfer after accept");
        while (sent < DATA_BYTES || fwd_busy) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout("the payload transfer to end");
            end
            // Random gaps with roughly one idle cycle in four
            r = $random(seed);
            in_byte_valid = (sent < DATA_BYTES) && (r[1:0] != 2'b00);
            in_byte = r[15:8];
            if (in_byte_valid) begin
                expected.push_back(in_byte);
                sent++;
            end
            tick();
            cycles++;
            if (out_byte_valid) begin
                assert (expected.size() > 0 && out_byte == expected[0]) else
                    report_mismatch($sformatf("payload byte %0d is %h", got, out_byte));
                void'(expected.pop_front());
                got++;
                assert (fwd_busy == (got < DATA_BYTES)) else
                    report_mismatch("fwd_busy did not fall with the last byte");
            end
        end
        // Input past the last byte finds the forwarder idle
        in_byte_valid = 1'b1;
        in_byte       = 8'hC3;
        repeat (3) begin
            tick();
            assert (!out_byte_valid) else
                report_mismatch("extra payload byte after the transfer");
        end
        in_byte_valid = 1'b0;
        assert (got == DATA_BYTES) else
            report_mismatch($sformatf("%0d payload bytes forwarded", got));
    endtask

    task automatic test_rejected_and_busy();
        offer_packet(64'hFEDC_BA98_7654_3210, 6'd33);
        // Second packet offered while the first waits on the PIT
        data_ready    = 1'b1;
        data_prefix   = 64'h1111_2222_3333_4444;
        data_len      = 6'd47;
        in_byte_valid = 1'b1;
        in_byte       = 8'h5A;
        repeat (3) begin
            tick();
            assert (query_valid && query_prefix == 64'hFEDC_BA98_7654_3210
                    && query_len == 6'd33 && !out_byte_valid) else
                report_mismatch("query changed while the forwarder was busy");
        end
        data_ready = 1'b0;
        reject_packet();
        repeat (4) begin
            tick();
            assert (!out_byte_valid && !query_valid) else
                report_mismatch("output after a rejected packet");
        end
        in_byte_valid = 1'b0;
        run_lookup(64'hFEDC_BA98_7654_3210, 6'd33);
        assert (got_hit && got_len == 6'd33) else
            report_mismatch("rejected packet was not learned");
        run_lookup(64'h1111_2222_3333_4444, 6'd47);
    endtask

    task automatic test_random_learning();
        prefix_t learned_p[10];
        int      learned_l[10];
        integer  r;
        int      k;
        int      len;
        for (int i = 0; i < 10; i++) begin
            learned_p[i] = {$random(seed), $random(seed)};
            r = $random(seed);
            learned_l[i] = r[5:0];
            learn_route(learned_p[i], plen_t'(learned_l[i]));
        end
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            if (i % 2 == 0) begin
                // Extend a learned prefix so a hit is likely
                k = (i / 2) % 10;
                len = learned_l[k] + (r[5:0] % (NUM_LENS - learned_l[k]));
                run_lookup(learned_p[k], plen_t'(len));
            end else begin
                run_lookup({$random(seed), $random(seed)}, plen_t'(r[5:0]));
            end
        end
    endtask

    initial begin
        seed          = 4;
        rst           = 1'b1;
        data_ready    = 1'b0;
        data_prefix   = '0;
        data_len      = '0;
        in_byte_valid = 1'b0;
        in_byte       = '0;
        pit_accept    = 1'b0;
        pit_reject    = 1'b0;
        lookup_valid  = 1'b0;
        lookup_prefix = '0;
        lookup_len    = '0;
        test_reset_state();
        test_exact_match();
        test_longest_prefix();
        test_accepted_transfer();
        test_rejected_and_busy();
        test_random_learning();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* ndn_fib.f */
design/ndn_fib_pkg.sv
design/prefix_hash.sv
design/fib_valid_table.sv
design/fib_route_learner.sv
design/fib_lpm_lookup.sv
design/content_forwarder.sv
design/ndn_fib.sv
testbench/ndn_fib_tb.sv
